//--- source/pipe_settings.svh
// stall vector bit positions, register count
// opcode, function, operation and result-group codes
`ifndef PIPE_SETTINGS_SVH
`define PIPE_SETTINGS_SVH

`define STALL_PC        0
`define STALL_IF        1
`define STALL_ID        2
`define STALL_EX        3

`define NUM_REGS        32

`define OP_SPECIAL      6'b000000
`define OP_SPECIAL2     6'b011100
`define OP_ORI          6'b001101
`define OP_ADDIU        6'b001001
`define OP_LUI          6'b001111

`define FN_ADDU         6'b100001
`define FN_SUBU         6'b100011
`define FN_AND          6'b100100
`define FN_OR           6'b100101
`define FN_XOR          6'b100110
`define FN_SLT          6'b101010
`define FN_SLL          6'b000000
`define FN_SRL          6'b000010
// function field under SPECIAL2
`define FN_MUL          6'b000010

`define ALU_NOP         8'b00000000
`define ALU_OR          8'b00100101
`define ALU_AND         8'b00100100
`define ALU_XOR         8'b00100110
`define ALU_ADD         8'b00100001
`define ALU_SUB         8'b00100011
`define ALU_SLT         8'b00101010
`define ALU_SLL         8'b01111100
`define ALU_SRL         8'b00000010
`define ALU_MUL         8'b10101001

`define SEL_NOP         3'b000
`define SEL_LOGIC       3'b001
`define SEL_SHIFT       3'b010
`define SEL_ARITH       3'b100
`define SEL_MUL         3'b101

`endif

//--- source/pipe_pkg.sv
// shared pipeline types: word, register address, operation codes,
// stall vector and multiplier state
package pipe_pkg;

        // data word, operand or result
        typedef logic [31:0] word_t;

        // register file index
        typedef logic [4:0] reg_addr_t;

        // operation code sent to execute
        typedef logic [7:0] alu_op_t;

        // result group
        typedef logic [2:0] alu_sel_t;

        // one bit per stage: pc, if, id, ex, mem, wb
        typedef logic [5:0] stall_vec_t;

        typedef enum logic {
                MUL_IDLE,
                MUL_BUSY
        } mul_state_t;

endpackage

//--- source/if_id.sv
// IF/ID register
`timescale 1ns/100ps
`include "pipe_settings.svh"

module if_id import pipe_pkg::*; (
        input  logic       clk,
        input  logic       rst_n,
        input  logic       flush,
        input  stall_vec_t stall,
        input  word_t      inst,
        output word_t      id_inst
);

        always_ff @(posedge clk)
        begin
                if (!rst_n || flush)
                        id_inst <= '0;
                else if (!stall[`STALL_IF])
                        id_inst <= inst;
                // otherwise hold
        end

endmodule

//--- source/regfile.sv
// register file, two async reads, one sync write, r0 fixed at zero
`timescale 1ns/100ps
`include "pipe_settings.svh"

module regfile import pipe_pkg::*; (
        input  logic      clk,
        input  logic      rst_n,
        input  logic      we,
        input  reg_addr_t waddr,
        input  word_t     wdata,
        input  reg_addr_t raddr1,
        input  reg_addr_t raddr2,
        output word_t     rdata1,
        output word_t     rdata2
);

        word_t regs [`NUM_REGS];

        always_ff @(posedge clk)
        begin
                if (!rst_n)
                begin
                        for (int i = 0; i < `NUM_REGS; i++)
                                regs[i] <= '0;
                end
                else if (we && waddr != '0)
                begin
                        regs[waddr] <= wdata;
                end
        end

        // no bypass here, decode forwards from writeback
        assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];
        assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];

endmodule

//--- source/id_decode.sv
// instruction decode, operand forwarding, MUL dependence stall request
`timescale 1ns/100ps
`include "pipe_settings.svh"

module id_decode import pipe_pkg::*; (
        input  word_t     id_inst,
        input  word_t     rdata1,
        input  word_t     rdata2,
        input  word_t     ex_result,
        input  word_t     wb_data,
        input  reg_addr_t ex_wd,
        input  reg_addr_t wb_addr,
        input  logic      ex_wreg,
        input  logic      ex_is_mul,
        input  logic      wb_we,
        output reg_addr_t raddr1,
        output reg_addr_t raddr2,
        output alu_op_t   aluop,
        output alu_sel_t  alusel,
        output word_t     reg1,
        output word_t     reg2,
        output reg_addr_t wd,
        output logic      wreg,
        output logic      stallreq_id
);

        logic [5:0] op;
        logic [5:0] fn;
        reg_addr_t  rs;
        reg_addr_t  rt;
        reg_addr_t  rd;
        logic [4:0] sa;
        logic [15:0] imm;

        logic  use_rs;
        logic  use_rt;
        logic  use_imm;
        logic  use_sa;
        word_t imm_val;

        assign op  = id_inst[31:26];
        assign rs  = id_inst[25:21];
        assign rt  = id_inst[20:16];
        assign rd  = id_inst[15:11];
        assign sa  = id_inst[10:6];
        assign fn  = id_inst[5:0];
        assign imm = id_inst[15:0];

        always_comb
        begin
                aluop   = `ALU_NOP;
                alusel  = `SEL_NOP;
                wd      = '0;
                use_rs  = 1'b0;
                use_rt  = 1'b0;
                use_imm = 1'b0;
                use_sa  = 1'b0;
                imm_val = '0;
                case (op)
                `OP_SPECIAL:
                begin
                        case (fn)
                        `FN_ADDU: {aluop, alusel} = {`ALU_ADD, `SEL_ARITH};
                        `FN_SUBU: {aluop, alusel} = {`ALU_SUB, `SEL_ARITH};
                        `FN_SLT:  {aluop, alusel} = {`ALU_SLT, `SEL_ARITH};
                        `FN_AND:  {aluop, alusel} = {`ALU_AND, `SEL_LOGIC};
                        `FN_OR:   {aluop, alusel} = {`ALU_OR, `SEL_LOGIC};
                        `FN_XOR:  {aluop, alusel} = {`ALU_XOR, `SEL_LOGIC};
                        `FN_SLL:  {aluop, alusel} = {`ALU_SLL, `SEL_SHIFT};
                        `FN_SRL:  {aluop, alusel} = {`ALU_SRL, `SEL_SHIFT};
                        default:  {aluop, alusel} = {`ALU_NOP, `SEL_NOP};
                        endcase
                        if (alusel != `SEL_NOP)
                        begin
                                wd     = rd;
                                use_rt = 1'b1;
                                // shift amount comes from sa, not rs
                                use_sa = (alusel == `SEL_SHIFT);
                                use_rs = (alusel != `SEL_SHIFT);
                        end
                end
                `OP_SPECIAL2:
                begin
                        if (fn == `FN_MUL)
                        begin
                                {aluop, alusel} = {`ALU_MUL, `SEL_MUL};
                                wd     = rd;
                                use_rs = 1'b1;
                                use_rt = 1'b1;
                        end
                end
                `OP_ORI:
                begin
                        {aluop, alusel} = {`ALU_OR, `SEL_LOGIC};
                        wd      = rt;
                        use_rs  = 1'b1;
                        use_imm = 1'b1;
                        imm_val = {16'h0000, imm};
                end
                `OP_ADDIU:
                begin
                        {aluop, alusel} = {`ALU_ADD, `SEL_ARITH};
                        wd      = rt;
                        use_rs  = 1'b1;
                        use_imm = 1'b1;
                        imm_val = {{16{imm[15]}}, imm};
                end
                `OP_LUI:
                begin
                        // or with zero
                        {aluop, alusel} = {`ALU_OR, `SEL_LOGIC};
                        wd      = rt;
                        use_imm = 1'b1;
                        imm_val = {imm, 16'h0000};
                end
                default:
                begin
                        wd = '0;
                end
                endcase
        end

        // the all-zero word lands here as sll to r0
        assign wreg = (alusel != `SEL_NOP) && (wd != '0);

        function automatic word_t fwd(input reg_addr_t addr, input word_t rdata);
                if (addr == '0)
                        return '0;
                else if (ex_wreg && ex_wd == addr)
                        return ex_result;
                else if (wb_we && wb_addr == addr)
                        return wb_data;
                return rdata;
        endfunction

        assign raddr1 = rs;
        assign raddr2 = rt;

        assign reg1 = use_sa ? {27'd0, sa} : (use_rs ? fwd(rs, rdata1) : '0);
        assign reg2 = use_imm ? imm_val : (use_rt ? fwd(rt, rdata2) : '0);

        // product not ready for forwarding while MUL sits in execute
        assign stallreq_id = ex_is_mul && ex_wreg &&
                             ((use_rs && rs == ex_wd) || (use_rt && rt == ex_wd));

endmodule

//--- source/id_ex.sv
// ID/EX register with flush, bubble insertion and hold
`timescale 1ns/100ps
`include "pipe_settings.svh"

module id_ex import pipe_pkg::*; (
        input  logic       clk,
        input  logic       rst_n,
        input  logic       flush,
        input  stall_vec_t stall,
        input  alu_op_t    id_aluop,
        input  alu_sel_t   id_alusel,
        input  word_t      id_reg1,
        input  word_t      id_reg2,
        input  reg_addr_t  id_wd,
        input  logic       id_wreg,
        output alu_op_t    ex_aluop,
        output alu_sel_t   ex_alusel,
        output word_t      ex_reg1,
        output word_t      ex_reg2,
        output reg_addr_t  ex_wd,
        output logic       ex_wreg
);

        logic bubble;

        // decode stopped while execute runs
        assign bubble = stall[`STALL_ID] && !stall[`STALL_EX];

        always_ff @(posedge clk)
        begin
                if (!rst_n || flush || bubble)
                begin
                        ex_aluop  <= `ALU_NOP;
                        ex_alusel <= `SEL_NOP;
                        ex_reg1   <= '0;
                        ex_reg2   <= '0;
                        ex_wd     <= '0;
                        ex_wreg   <= 1'b0;
                end
                else if (!stall[`STALL_ID])
                begin
                        ex_aluop  <= id_aluop;
                        ex_alusel <= id_alusel;
                        ex_reg1   <= id_reg1;
                        ex_reg2   <= id_reg2;
                        ex_wd     <= id_wd;
                        ex_wreg   <= id_wreg;
                end
                // both stopped, hold
        end

endmodule

//--- source/ex_stage.sv
// execute: ALU, shifter, two-cycle multiplier, EX/WB register
`timescale 1ns/100ps
`include "pipe_settings.svh"

module ex_stage import pipe_pkg::*; (
        input  logic       clk,
        input  logic       rst_n,
        input  stall_vec_t stall,
        input  alu_op_t    ex_aluop,
        input  alu_sel_t   ex_alusel,
        input  word_t      ex_reg1,
        input  word_t      ex_reg2,
        input  reg_addr_t  ex_wd,
        input  logic       ex_wreg,
        output word_t      ex_result,
        output logic       ex_is_mul,
        output logic       stallreq_ex,
        output logic       wb_we,
        output reg_addr_t  wb_addr,
        output word_t      wb_data
);

        mul_state_t mul_state;
        word_t      mul_prod;
        word_t      logic_res;
        word_t      shift_res;
        word_t      arith_res;
        logic       mul_start;

        always_comb
        begin
                logic_res = '0;
                shift_res = '0;
                arith_res = '0;
                case (ex_aluop)
                `ALU_OR:  logic_res = ex_reg1 | ex_reg2;
                `ALU_AND: logic_res = ex_reg1 & ex_reg2;
                `ALU_XOR: logic_res = ex_reg1 ^ ex_reg2;
                `ALU_SLL: shift_res = ex_reg2 << ex_reg1[4:0];
                `ALU_SRL: shift_res = ex_reg2 >> ex_reg1[4:0];
                `ALU_ADD: arith_res = ex_reg1 + ex_reg2;
                `ALU_SUB: arith_res = ex_reg1 - ex_reg2;
                `ALU_SLT: arith_res = {31'd0, $signed(ex_reg1) < $signed(ex_reg2)};
                default:  logic_res = '0;
                endcase
        end

        always_comb
        begin
                case (ex_alusel)
                `SEL_LOGIC: ex_result = logic_res;
                `SEL_SHIFT: ex_result = shift_res;
                `SEL_ARITH: ex_result = arith_res;
                `SEL_MUL:   ex_result = mul_prod;
                default:    ex_result = '0;
                endcase
        end

        assign ex_is_mul   = (ex_alusel == `SEL_MUL);
        assign mul_start   = ex_is_mul && (mul_state == MUL_IDLE);
        assign stallreq_ex = mul_start;

        // first cycle captures the product, second cycle completes
        always_ff @(posedge clk)
        begin
                if (!rst_n)
                        mul_state <= MUL_IDLE;
                else if (mul_start)
                        mul_state <= MUL_BUSY;
                else
                        mul_state <= MUL_IDLE;
        end

        always_ff @(posedge clk)
        begin
                if (mul_start)
                        mul_prod <= ex_reg1 * ex_reg2;
        end

        always_ff @(posedge clk)
        begin
                if (!rst_n)
                begin
                        wb_we   <= 1'b0;
                        wb_addr <= '0;
                        wb_data <= '0;
                end
                else if (stall[`STALL_EX])
                begin
                        // execute stopped, nothing to write
                        wb_we   <= 1'b0;
                        wb_addr <= '0;
                end
                else
                begin
                        wb_we   <= ex_wreg;
                        wb_addr <= ex_wd;
                        wb_data <= ex_result;
                end
        end

endmodule

//--- source/pipe_ctrl.sv
// stall controller
`timescale 1ns/100ps
`include "pipe_settings.svh"

module pipe_ctrl import pipe_pkg::*; (
        input  logic       rst_n,
        input  logic       stallreq_id,
        input  logic       stallreq_ex,
        output stall_vec_t stall
);

        always_comb
        begin
                stall = '0;
                if (rst_n && stallreq_ex)
                begin
                        stall[`STALL_PC] = 1'b1;
                        stall[`STALL_IF] = 1'b1;
                        stall[`STALL_ID] = 1'b1;
                        stall[`STALL_EX] = 1'b1;
                end
                else if (rst_n && stallreq_id)
                begin
                        stall[`STALL_PC] = 1'b1;
                        stall[`STALL_IF] = 1'b1;
                        stall[`STALL_ID] = 1'b1;
                end
        end

endmodule

//--- source/core_slice.sv
// pipeline slice top: IF/ID, decode, register file, ID/EX, execute, stall control
`timescale 1ns/100ps
`include "pipe_settings.svh"

module core_slice import pipe_pkg::*; (
        input  logic      clk,
        input  logic      rst_n,
        input  logic      flush,
        input  word_t     inst,
        output logic      fetch_stall,
        output logic      wb_we,
        output reg_addr_t wb_addr,
        output word_t     wb_data
);

        stall_vec_t stall;
        word_t      id_inst;
        reg_addr_t  raddr1;
        reg_addr_t  raddr2;
        word_t      rdata1;
        word_t      rdata2;
        alu_op_t    id_aluop;
        alu_sel_t   id_alusel;
        word_t      id_reg1;
        word_t      id_reg2;
        reg_addr_t  id_wd;
        logic       id_wreg;
        alu_op_t    ex_aluop;
        alu_sel_t   ex_alusel;
        word_t      ex_reg1;
        word_t      ex_reg2;
        reg_addr_t  ex_wd;
        logic       ex_wreg;
        word_t      ex_result;
        logic       ex_is_mul;
        logic       stallreq_id;
        logic       stallreq_ex;

        assign fetch_stall = stall[`STALL_IF];

        if_id if_id_i (
                .clk(clk), .rst_n(rst_n), .flush(flush), .stall(stall),
                .inst(inst), .id_inst(id_inst)
        );

        id_decode id_decode_i (
                .id_inst(id_inst), .rdata1(rdata1), .rdata2(rdata2),
                .ex_result(ex_result), .wb_data(wb_data),
                .ex_wd(ex_wd), .wb_addr(wb_addr),
                .ex_wreg(ex_wreg), .ex_is_mul(ex_is_mul), .wb_we(wb_we),
                .raddr1(raddr1), .raddr2(raddr2),
                .aluop(id_aluop), .alusel(id_alusel),
                .reg1(id_reg1), .reg2(id_reg2),
                .wd(id_wd), .wreg(id_wreg), .stallreq_id(stallreq_id)
        );

        regfile regfile_i (
                .clk(clk), .rst_n(rst_n),
                .we(wb_we), .waddr(wb_addr), .wdata(wb_data),
                .raddr1(raddr1), .raddr2(raddr2),
                .rdata1(rdata1), .rdata2(rdata2)
        );

        id_ex id_ex_i (
                .clk(clk), .rst_n(rst_n), .flush(flush), .stall(stall),
                .id_aluop(id_aluop), .id_alusel(id_alusel),
                .id_reg1(id_reg1), .id_reg2(id_reg2),
                .id_wd(id_wd), .id_wreg(id_wreg),
                .ex_aluop(ex_aluop), .ex_alusel(ex_alusel),
                .ex_reg1(ex_reg1), .ex_reg2(ex_reg2),
                .ex_wd(ex_wd), .ex_wreg(ex_wreg)
        );

        ex_stage ex_stage_i (
                .clk(clk), .rst_n(rst_n), .stall(stall),
                .ex_aluop(ex_aluop), .ex_alusel(ex_alusel),
                .ex_reg1(ex_reg1), .ex_reg2(ex_reg2),
                .ex_wd(ex_wd), .ex_wreg(ex_wreg),
                .ex_result(ex_result), .ex_is_mul(ex_is_mul),
                .stallreq_ex(stallreq_ex),
                .wb_we(wb_we), .wb_addr(wb_addr), .wb_data(wb_data)
        );

        pipe_ctrl pipe_ctrl_i (
                .rst_n(rst_n), .stallreq_id(stallreq_id),
                .stallreq_ex(stallreq_ex), .stall(stall)
        );

endmodule

//--- testbench/core_slice_sva_chk.sv
// bound assertions on writeback address, stall vector shape and input hold
`timescale 1ns/100ps

module core_slice_sva_chk import pipe_pkg::*; (
        input logic       clk,
        input logic       rst_n,
        input word_t      inst,
        input logic       fetch_stall,
        input logic       wb_we,
        input reg_addr_t  wb_addr,
        input stall_vec_t stall
);

        int fail_count = 0;

        // register 0 is never a write target
        wb_addr_nonzero: assert property (@(posedge clk) disable iff (!rst_n)
                wb_we |-> wb_addr != '0)
        else
        begin
                $error("writeback to register 0");
                fail_count++;
        end

        // a stage stops only if every earlier stage stops too
        stall_monotone: assert property (@(posedge clk) disable iff (!rst_n)
                (stall[5:1] & ~stall[4:0]) == '0)
        else
        begin
                $error("stall vector not monotone: %b", stall);
                fail_count++;
        end

        // source keeps the word until it is taken
        inst_held: assert property (@(posedge clk) disable iff (!rst_n)
                fetch_stall |=> $stable(inst))
        else
        begin
                $error("inst changed while fetch_stall was high");
                fail_count++;
        end

endmodule

bind core_slice core_slice_sva_chk sva_i (
        .clk(clk), .rst_n(rst_n), .inst(inst), .fetch_stall(fetch_stall),
        .wb_we(wb_we), .wb_addr(wb_addr), .stall(stall)
);

//--- testbench/core_slice_mon.sv
// writeback monitor, compares each register write with the expected queue
`timescale 1ns/100ps

module core_slice_mon import pipe_pkg::*; (
        input  logic      clk,
        input  logic      rst_n,
        input  logic      wb_we,
        input  reg_addr_t wb_addr,
        input  word_t     wb_data
);

        // expected writes in program order, {addr, data}
        logic [36:0] exp_q [$];
        int          errors = 0;
        int          writes = 0;
        reg_addr_t   exp_addr;
        word_t       exp_data;

        // writeback outputs are settled by the falling edge
        always @(negedge clk)
        begin
                if (rst_n && wb_we)
                begin
                        writes++;
                        if (exp_q.size() == 0)
                        begin
                                $display("unexpected write of %h to r%0d at %0t ns, none pending",
                                         wb_data, wb_addr, $time);
                                errors++;
                        end
                        else
                        begin
                                {exp_addr, exp_data} = exp_q.pop_front();
                                if (wb_addr !== exp_addr || wb_data !== exp_data)
                                begin
                                        $display("Error at %0t ns: expected r%0d = %h, got r%0d = %h",
                                                 $time, exp_addr, exp_data, wb_addr, wb_data);
                                        errors++;
                                end
                        end
                end
        end

endmodule

//--- testbench/core_slice_tb.sv
// testbench for the pipeline slice: clock, reset, instruction stimulus,
// reference model, timeout and final report
`timescale 1ns/100ps
`include "pipe_settings.svh"

module core_slice_tb import pipe_pkg::*; ();

        localparam int N_SEED  = 8;
        localparam int N_RAND  = 40;
        localparam int N_FWD   = 10;
        localparam int N_MUL   = 8;
        localparam int N_FLUSH = 7;
        localparam int N_ZERO  = 9;
        localparam int N_INSTS = 2 * N_SEED + N_RAND + N_FWD + N_MUL + N_FLUSH + N_ZERO;
        localparam int MAX_CYCLES = N_INSTS * 4 + 100;

        logic      clk = 1'b0;
        logic      rst_n;
        logic      flush;
        word_t     inst;
        logic      fetch_stall;
        logic      wb_we;
        reg_addr_t wb_addr;
        word_t     wb_data;

        integer seed = 32'hfa94296e;
        word_t  model [`NUM_REGS];
        // register state before the last accepted instruction
        word_t  snap0 [`NUM_REGS];
        logic   pushed0;
        int     fails = 0;
        int     cycles = 0;
        int     stall_cycles = 0;
        int     test_num = 0;
        int     errs_before = 0;

        always #2 clk = ~clk;

        core_slice dut_i (
                .clk(clk), .rst_n(rst_n), .flush(flush), .inst(inst),
                .fetch_stall(fetch_stall), .wb_we(wb_we), .wb_addr(wb_addr), .wb_data(wb_data)
        );

        core_slice_mon mon_i (
                .clk(clk), .rst_n(rst_n), .wb_we(wb_we), .wb_addr(wb_addr), .wb_data(wb_data)
        );

        always @(negedge clk)
        begin
                if (rst_n && fetch_stall)
                        stall_cycles++;
        end

        function automatic word_t r_form(input logic [5:0] fn, input int rs, input int rt,
                                         input int rd);
                return {`OP_SPECIAL, 5'(rs), 5'(rt), 5'(rd), 5'd0, fn};
        endfunction

        function automatic word_t sh_form(input logic [5:0] fn, input int rt, input int rd,
                                          input int sa);
                return {`OP_SPECIAL, 5'd0, 5'(rt), 5'(rd), 5'(sa), fn};
        endfunction

        function automatic word_t i_form(input logic [5:0] op, input int rs, input int rt,
                                         input word_t imm);
                return {op, 5'(rs), 5'(rt), imm[15:0]};
        endfunction

        function automatic word_t mul_form(input int rs, input int rt, input int rd);
                return {`OP_SPECIAL2, 5'(rs), 5'(rt), 5'(rd), 5'd0, `FN_MUL};
        endfunction

        // expected {destination, value}, destination 0 means no write
        function automatic logic [36:0] ref_exec(input word_t w, input word_t regs [`NUM_REGS]);
                word_t     a;
                word_t     b;
                reg_addr_t dest;
                word_t     val;
                a = regs[w[25:21]];
                b = regs[w[20:16]];
                dest = '0;
                val = '0;
                case (w[31:26])
                `OP_SPECIAL:
                begin
                        dest = w[15:11];
                        case (w[5:0])
                        `FN_ADDU: val = a + b;
                        `FN_SUBU: val = a - b;
                        `FN_AND:  val = a & b;
                        `FN_OR:   val = a | b;
                        `FN_XOR:  val = a ^ b;
                        `FN_SLT:  val = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                        `FN_SLL:  val = b << w[10:6];
                        `FN_SRL:  val = b >> w[10:6];
                        default:  dest = '0;
                        endcase
                end
                `OP_SPECIAL2:
                begin
                        if (w[5:0] == `FN_MUL)
                        begin
                                dest = w[15:11];
                                val = a * b;
                        end
                end
                `OP_ORI:
                begin
                        dest = w[20:16];
                        val = a | {16'h0000, w[15:0]};
                end
                `OP_ADDIU:
                begin
                        dest = w[20:16];
                        val = a + {{16{w[15]}}, w[15:0]};
                end
                `OP_LUI:
                begin
                        dest = w[20:16];
                        val = {w[15:0], 16'h0000};
                end
                default:
                        dest = '0;
                endcase
                return {dest, val};
        endfunction

        function automatic int error_total();
                return mon_i.errors + fails + dut_i.sva_i.fail_count;
        endfunction

        // present a word and hold it until an edge with fetch_stall low
        task automatic issue(input word_t w);
                logic [36:0] res;
                inst = w;
                @(negedge clk);
                while (fetch_stall)
                        @(negedge clk);
                @(posedge clk);
                res = ref_exec(w, model);
                snap0 = model;
                pushed0 = (res[36:32] != '0);
                if (pushed0)
                begin
                        mon_i.exp_q.push_back(res);
                        model[res[36:32]] = res[31:0];
                end
                #0.5;
                inst = '0;
        endtask

        // newest instruction in IF/ID is dropped
        // ID/EX moves on to EX/WB at the same edge and completes
        task automatic flush_pipe();
                flush = 1'b1;
                @(posedge clk);
                model = snap0;
                if (pushed0)
                        void'(mon_i.exp_q.pop_back());
                pushed0 = 1'b0;
                #0.5;
                flush = 1'b0;
        endtask

        task automatic finish_test(input string name);
                while (mon_i.exp_q.size() != 0)
                begin
                        @(posedge clk);
                        #0.5;
                end
                // let stray writebacks show up
                repeat (6) @(posedge clk);
                #0.5;
                test_num++;
                $display("test %0d %s: %0d errors", test_num, name, error_total() - errs_before);
                errs_before = error_total();
        endtask

        initial
        begin
                word_t w;
                word_t rnd;
                int    sel;
                int    rs;
                int    rt;
                int    rd;
                int    stall_before;
                rst_n = 1'b0;
                flush = 1'b0;
                inst = '0;
                pushed0 = 1'b0;
                for (int r = 0; r < `NUM_REGS; r++)
                        model[r] = '0;
                repeat (8) @(posedge clk);
                #0.5;
                rst_n = 1'b1;

                for (int r = 1; r <= N_SEED; r++)
                begin
                        issue(i_form(`OP_LUI, 0, r, $random(seed)));
                        issue(i_form(`OP_ORI, r, r, $random(seed)));
                end
                for (int n = 0; n < N_RAND; n++)
                begin
                        rnd = $random(seed);
                        sel = $unsigned($random(seed)) % 11;
                        rs = rnd[3:0];
                        rt = rnd[7:4];
                        rd = 1 + (rnd[11:8] % 15);
                        case (sel)
                        0:       w = r_form(`FN_ADDU, rs, rt, rd);
                        1:       w = r_form(`FN_SUBU, rs, rt, rd);
                        2:       w = r_form(`FN_AND, rs, rt, rd);
                        3:       w = r_form(`FN_OR, rs, rt, rd);
                        4:       w = r_form(`FN_XOR, rs, rt, rd);
                        5:       w = r_form(`FN_SLT, rs, rt, rd);
                        6:       w = sh_form(`FN_SLL, rt, rd, rnd[16:12]);
                        7:       w = sh_form(`FN_SRL, rt, rd, rnd[16:12]);
                        8:       w = i_form(`OP_ORI, rs, rd, rnd >> 16);
                        9:       w = i_form(`OP_ADDIU, rs, rd, rnd >> 16);
                        default: w = i_form(`OP_LUI, 0, rd, rnd >> 16);
                        endcase
                        issue(w);
                end
                finish_test("alu and immediate forms");

                issue(i_form(`OP_ADDIU, 0, 20, 32'h1234));
                issue(r_form(`FN_ADDU, 20, 20, 21));
                issue(r_form(`FN_XOR, 20, 21, 22));
                issue(r_form(`FN_SUBU, 22, 20, 23));
                issue(sh_form(`FN_SLL, 23, 24, 3));
                issue(sh_form(`FN_SRL, 24, 25, 7));
                issue(r_form(`FN_SLT, 20, 25, 26));
                issue(i_form(`OP_ORI, 26, 27, 32'hff00));
                issue(i_form(`OP_ADDIU, 27, 28, 32'h8001));
                issue(r_form(`FN_AND, 28, 24, 29));
                finish_test("forwarding at distance 1 and 2");

                stall_before = stall_cycles;
                issue(mul_form(1, 2, 10));
                issue(r_form(`FN_ADDU, 10, 3, 11));
                issue(mul_form(10, 11, 12));
                issue(mul_form(12, 12, 13));
                issue(r_form(`FN_XOR, 13, 12, 14));
                issue(mul_form(4, 5, 15));
                issue(r_form(`FN_OR, 6, 7, 16));
                issue(r_form(`FN_SUBU, 15, 16, 17));
                if (stall_cycles - stall_before < 4)
                begin
                        $display("fetch_stall was high for only %0d cycles during four MULs",
                                 stall_cycles - stall_before);
                        fails++;
                end
                finish_test("multiply chains");

                issue(i_form(`OP_ADDIU, 0, 18, 32'h0111));
                issue(i_form(`OP_ADDIU, 0, 19, 32'h0222));
                issue(i_form(`OP_ADDIU, 0, 18, 32'h0333));
                issue(i_form(`OP_ADDIU, 0, 19, 32'h0444));
                flush_pipe();
                issue(r_form(`FN_ADDU, 18, 19, 20));
                issue(i_form(`OP_ORI, 19, 21, 32'h0f0f));
                issue(r_form(`FN_XOR, 20, 21, 22));
                finish_test("flush");

                issue(r_form(`FN_ADDU, 1, 2, 0));
                issue(i_form(`OP_ORI, 3, 0, 32'hffff));
                issue(i_form(`OP_LUI, 0, 0, 32'habcd));
                issue(mul_form(4, 5, 0));
                issue(sh_form(`FN_SLL, 6, 0, 4));
                issue(32'h8c22_0004);
                issue(r_form(6'b001000, 1, 2, 7));
                issue({`OP_SPECIAL2, 5'd1, 5'd2, 5'd3, 5'd0, 6'b000001});
                issue(r_form(`FN_ADDU, 0, 1, 29));
                finish_test("register 0 and unknown encodings");

                if (mon_i.exp_q.size() != 0)
                begin
                        $display("%0d expected writebacks never appeared", mon_i.exp_q.size());
                        fails++;
                end
                $display("tests: %0d, writebacks checked: %0d, errors: %0d",
                         test_num, mon_i.writes, error_total());
                if (error_total() == 0)
                        $display("STATUS: PASS");
                else
                        $display("STATUS: FAIL");
                $finish;
        end

        initial
        begin
                while (cycles < MAX_CYCLES)
                begin
                        @(posedge clk);
                        cycles++;
                end
                $display("timeout: run still going after %0d cycles", MAX_CYCLES);
                $display("STATUS: FAIL");
                $finish;
        end

endmodule

//--- build.f
+incdir+source
source/pipe_pkg.sv
source/if_id.sv
source/regfile.sv
source/id_decode.sv
source/id_ex.sv
source/ex_stage.sv
source/pipe_ctrl.sv
source/core_slice.sv
testbench/core_slice_sva_chk.sv
testbench/core_slice_mon.sv
testbench/core_slice_tb.sv

//--- run.sh
#!/bin/sh
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal --top-module core_slice_tb -f build.f \
        -o core_slice_sim && ./obj_dir/core_slice_sim > sim.log 2>&1 || echo "simulation did not complete"
cat sim.log 2>/dev/null
grep -q "STATUS: FAIL" sim.log && exit 1
grep -q "STATUS: PASS" sim.log || exit 1
exit 0
